/* src/riscv_isa_pkg.sv */
// RV32 instruction encodings used by the multiply/divide unit
// only the fixed 32-bit instruction format is described here

package riscv_isa_pkg;

  ////////////////////////////////
  // major opcodes
  ////////////////////////////////

  // bits [1:0] are always 2'b11 for 32-bit instructions
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_LOAD_FP   = 7'b0000111,
    OPC_MISC_MEM  = 7'b0001111,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_STORE_FP  = 7'b0100111,
    OPC_AMO       = 7'b0101111,
    // register-register ALU ops, M extension lives here
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_t;

  // M extension funct3 codes, all eight values are used
  typedef enum logic [2:0] {
    F_MUL    = 3'b000,
    F_MULH   = 3'b001,
    F_MULHSU = 3'b010,
    F_MULHU  = 3'b011,
    F_DIV    = 3'b100,
    F_DIVU   = 3'b101,
    F_REM    = 3'b110,
    F_REMU   = 3'b111
  } funct3_m_t;

  // funct7 that marks MULDIV in the OP space
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // R-type layout, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_m_t  funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } inst_t;

endpackage

/* src/mdu_pkg.sv */
// internal control types of the multiply/divide unit
// independent of XLEN, datapath widths come from module parameters

package mdu_pkg;

  ////////////////////////////////
  // operation classes
  ////////////////////////////////

  // funct3 collapses to four result selections
  // signedness is carried separately in ctl_t
  typedef enum logic [1:0] {
    OP_MUL_LO = 2'd0,
    OP_MUL_HI = 2'd1,
    OP_DIV    = 2'd2,
    OP_REM    = 2'd3
  } mdu_op_t;

  // decoded control, held by decode for the whole operation
  typedef struct packed {
    mdu_op_t op;
    // rs1 treated as signed
    logic    sign1;
    // rs2 treated as signed
    logic    sign2;
    // not an M instruction, rd forced to zero
    logic    illegal;
  } ctl_t;

  // flags from execute, consumed by result
  typedef struct packed {
    // product must be negated
    logic neg_prod;
    // quotient must be negated, never set on divide by zero
    logic neg_quot;
    // remainder follows dividend sign
    logic neg_rem;
    // divisor was zero
    logic div_zero;
    // most negative / -1
    logic overflow;
  } exe_flags_t;

  ////////////////////////////////
  // state machines
  ////////////////////////////////

  // acceptance fsm in decode
  typedef enum logic {
    DEC_IDLE = 1'b0,
    DEC_BUSY = 1'b1
  } dec_state_t;

  // iteration fsm in execute
  typedef enum logic [1:0] {
    EXE_IDLE = 2'd0,
    EXE_MUL  = 2'd1,
    EXE_DIV  = 2'd2,
    EXE_DONE = 2'd3
  } exe_state_t;

endpackage

/* src/mdu_decode.sv */
// accepts one request at a time on the four-phase req handshake
// operands and control are held until the next acceptance

module mdu_decode #(
  parameter int unsigned XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  riscv_isa_pkg::inst_t inst,
  input  logic [XLEN-1:0]      rs1_in,
  input  logic [XLEN-1:0]      rs2_in,
  output logic                 start,
  output mdu_pkg::ctl_t        ctl,
  output logic [XLEN-1:0]      opa,
  output logic [XLEN-1:0]      opb,
  output logic                 release_ack
);

  import riscv_isa_pkg::*;
  import mdu_pkg::*;

  dec_state_t state;
  ctl_t       ctl_d;
  logic       accept;

  // new request only while idle
  assign accept = (state == DEC_IDLE) && req;

  ////////////////////////////////
  // instruction decode
  ////////////////////////////////

  always_comb begin
    ctl_d.op      = OP_MUL_LO;
    ctl_d.sign1   = 1'b0;
    ctl_d.sign2   = 1'b0;
    ctl_d.illegal = 1'b0;
    // anything outside OP with MULDIV funct7
    if ((inst.opcode != OPC_OP) || (inst.funct7 != FUNCT7_MULDIV)) begin
      ctl_d.illegal = 1'b1;
    end else begin
      case (inst.funct3)
        F_MUL:    ctl_d.op = OP_MUL_LO;
        F_MULH: begin
          ctl_d.op    = OP_MUL_HI;
          ctl_d.sign1 = 1'b1;
          ctl_d.sign2 = 1'b1;
        end
        // signed rs1 times unsigned rs2
        F_MULHSU: begin
          ctl_d.op    = OP_MUL_HI;
          ctl_d.sign1 = 1'b1;
        end
        F_MULHU:  ctl_d.op = OP_MUL_HI;
        F_DIV: begin
          ctl_d.op    = OP_DIV;
          ctl_d.sign1 = 1'b1;
          ctl_d.sign2 = 1'b1;
        end
        F_DIVU:   ctl_d.op = OP_DIV;
        F_REM: begin
          ctl_d.op    = OP_REM;
          ctl_d.sign1 = 1'b1;
          ctl_d.sign2 = 1'b1;
        end
        F_REMU:   ctl_d.op = OP_REM;
        default:  ctl_d.illegal = 1'b1;
      endcase
    end
  end

  ////////////////////////////////
  // acceptance fsm
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= DEC_IDLE;
      start       <= 1'b0;
      release_ack <= 1'b0;
    end else begin
      // both are single cycle pulses
      start       <= 1'b0;
      release_ack <= 1'b0;
      case (state)
        DEC_IDLE: begin
          if (req) begin
            start <= 1'b1;
            state <= DEC_BUSY;
          end
        end
        // req low here ends the transfer since it falls only after ack
        DEC_BUSY: begin
          if (!req) begin
            release_ack <= 1'b1;
            state       <= DEC_IDLE;
          end
        end
        default: state <= DEC_IDLE;
      endcase
    end
  end

  // operand and control capture
  always_ff @(posedge clk) begin
    if (accept) begin
      ctl <= ctl_d;
      opa <= rs1_in;
      opb <= rs2_in;
    end
  end

endmodule

/* src/mdu_execute.sv */
// iterative shift-add multiplier and restoring divider on magnitudes
// XLEN+1 cycles per normal op, one cycle for special cases and illegal

module mdu_execute #(
  parameter int unsigned XLEN = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  mdu_pkg::ctl_t       ctl,
  input  logic [XLEN-1:0]     opa,
  input  logic [XLEN-1:0]     opb,
  output logic                done,
  output logic [XLEN-1:0]     prod_hi,
  output logic [XLEN-1:0]     prod_lo,
  output logic [XLEN-1:0]     quot,
  output logic [XLEN-1:0]     rem,
  output mdu_pkg::exe_flags_t flags
);

  import mdu_pkg::*;

  // step counter width
  localparam int unsigned CW = $clog2(XLEN);
  // most negative value
  localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

  exe_state_t      state;
  logic [CW-1:0]   cnt;
  logic            last_step;

  // shared datapath registers
  // mul: acc_hi/acc_lo is the product, opd the multiplicand
  // div: acc_hi is the partial remainder, acc_lo the quotient, opd the divisor
  logic [XLEN-1:0] acc_hi;
  logic [XLEN-1:0] acc_lo;
  logic [XLEN-1:0] opd;

  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic            is_div;
  logic            div_zero;
  logic            overflow;
  logic            skip;

  logic [XLEN:0]   mul_sum;
  logic [XLEN:0]   div_shift;
  logic [XLEN:0]   div_diff;
  logic            div_ge;

  ////////////////////////////////
  // operand preparation
  ////////////////////////////////

  assign a_neg = ctl.sign1 & opa[XLEN-1];
  assign b_neg = ctl.sign2 & opb[XLEN-1];
  // -MIN_NEG wraps to itself, which is the right unsigned magnitude
  assign a_mag = a_neg ? (~opa + 1'b1) : opa;
  assign b_mag = b_neg ? (~opb + 1'b1) : opb;

  assign is_div   = (ctl.op == OP_DIV) || (ctl.op == OP_REM);
  assign div_zero = is_div && (opb == '0);
  assign overflow = is_div && ctl.sign1 && ctl.sign2 && (opa == MIN_NEG) && (opb == '1);
  // no iteration needed
  assign skip     = ctl.illegal || div_zero || overflow;

  ////////////////////////////////
  // step logic
  ////////////////////////////////

  // add multiplicand when the current multiplier bit is set
  assign mul_sum = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, opd} : {(XLEN+1){1'b0}});

  // bring next dividend bit into the partial remainder
  assign div_shift = {acc_hi, acc_lo[XLEN-1]};
  assign div_diff  = div_shift - {1'b0, opd};
  assign div_ge    = (div_shift >= {1'b0, opd});

  assign last_step = (cnt == CW'(XLEN-1));

  // control fsm
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= EXE_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        EXE_IDLE: begin
          if (start) begin
            cnt <= '0;
            if (skip) begin
              state <= EXE_DONE;
            end else if (is_div) begin
              state <= EXE_DIV;
            end else begin
              state <= EXE_MUL;
            end
          end
        end
        EXE_MUL, EXE_DIV: begin
          cnt <= cnt + 1'b1;
          if (last_step) begin
            state <= EXE_DONE;
          end
        end
        EXE_DONE: state <= EXE_IDLE;
        default:  state <= EXE_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if ((state == EXE_IDLE) && start) begin
      // divide by zero leaves |rs1| as remainder, result restores the sign
      acc_hi         <= div_zero ? a_mag : '0;
      acc_lo         <= is_div ? a_mag : b_mag;
      opd            <= is_div ? b_mag : a_mag;
      flags.neg_prod <= a_neg ^ b_neg;
      flags.neg_quot <= (a_neg ^ b_neg) & ~div_zero;
      flags.neg_rem  <= a_neg;
      flags.div_zero <= div_zero;
      flags.overflow <= overflow;
    end else if (state == EXE_MUL) begin
      // shift product right with the adder carry
      acc_hi <= mul_sum[XLEN:1];
      acc_lo <= {mul_sum[0], acc_lo[XLEN-1:1]};
    end else if (state == EXE_DIV) begin
      // restoring step, quotient bit shifts in at the bottom
      acc_hi <= div_ge ? div_diff[XLEN-1:0] : div_shift[XLEN-1:0];
      acc_lo <= {acc_lo[XLEN-2:0], div_ge};
    end
  end

  // single cycle completion
  assign done    = (state == EXE_DONE);

  assign prod_hi = acc_hi;
  assign prod_lo = acc_lo;
  assign quot    = acc_lo;
  assign rem     = acc_hi;

endmodule

/* src/mdu_result.sv */
// sign fix-up and result selection, drives rd, illegal and ack
// rd and illegal hold while ack is high

module mdu_result #(
  parameter int unsigned XLEN = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                done,
  input  mdu_pkg::ctl_t       ctl,
  input  logic [XLEN-1:0]     prod_hi,
  input  logic [XLEN-1:0]     prod_lo,
  input  logic [XLEN-1:0]     quot,
  input  logic [XLEN-1:0]     rem,
  input  mdu_pkg::exe_flags_t flags,
  input  logic                release_ack,
  output logic [XLEN-1:0]     rd,
  output logic                illegal,
  output logic                ack
);

  import mdu_pkg::*;

  localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic [2*XLEN-1:0] prod_mag;
  logic [2*XLEN-1:0] prod_sgn;
  logic [XLEN-1:0]   quot_sgn;
  logic [XLEN-1:0]   rem_sgn;
  logic [XLEN-1:0]   rd_d;

  ////////////////////////////////
  // sign fix-up
  ////////////////////////////////

  // full width product so the upper half gets the borrow
  assign prod_mag = {prod_hi, prod_lo};
  assign prod_sgn = flags.neg_prod ? (~prod_mag + 1'b1) : prod_mag;
  assign quot_sgn = flags.neg_quot ? (~quot + 1'b1) : quot;
  // on divide by zero this rebuilds rs1
  assign rem_sgn  = flags.neg_rem ? (~rem + 1'b1) : rem;

  always_comb begin
    case (ctl.op)
      OP_MUL_LO: rd_d = prod_sgn[XLEN-1:0];
      OP_MUL_HI: rd_d = prod_sgn[2*XLEN-1:XLEN];
      // special quotients override the datapath
      OP_DIV:    rd_d = flags.div_zero ? '1 : (flags.overflow ? MIN_NEG : quot_sgn);
      OP_REM:    rd_d = flags.overflow ? '0 : rem_sgn;
      default:   rd_d = '0;
    endcase
    if (ctl.illegal) begin
      rd_d = '0;
    end
  end

  ////////////////////////////////
  // output registers
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (done) begin
      rd      <= rd_d;
      illegal <= ctl.illegal;
    end
  end

  // ack high one edge after done, low one edge after release
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else if (done) begin
      ack <= 1'b1;
    end else if (release_ack) begin
      ack <= 1'b0;
    end
  end

endmodule

/* src/mdu_top.sv */
// RISC-V M extension unit behind a four-phase req/ack handshake
// one operation in flight, latency varies, ack marks completion

module mdu_top #(
  parameter int unsigned XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  riscv_isa_pkg::inst_t inst,
  input  logic [XLEN-1:0]      rs1,
  input  logic [XLEN-1:0]      rs2,
  output logic                 ack,
  output logic [XLEN-1:0]      rd,
  output logic                 illegal
);

  import mdu_pkg::*;

  // decode to execute
  logic            start;
  ctl_t            ctl;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  // decode to result
  logic            release_ack;
  // execute to result
  logic            done;
  logic [XLEN-1:0] prod_hi;
  logic [XLEN-1:0] prod_lo;
  logic [XLEN-1:0] quot;
  logic [XLEN-1:0] rem;
  exe_flags_t      flags;

  ////////////////////////////////
  // submodules
  ////////////////////////////////

  mdu_decode #(.XLEN(XLEN)) decode_i (
    .clk(clk), .rst_n(rst_n), .req(req), .inst(inst),
    .rs1_in(rs1), .rs2_in(rs2),
    .start(start), .ctl(ctl), .opa(opa), .opb(opb),
    .release_ack(release_ack)
  );

  mdu_execute #(.XLEN(XLEN)) execute_i (
    .clk(clk), .rst_n(rst_n), .start(start), .ctl(ctl), .opa(opa), .opb(opb),
    .done(done), .prod_hi(prod_hi), .prod_lo(prod_lo),
    .quot(quot), .rem(rem), .flags(flags)
  );

  mdu_result #(.XLEN(XLEN)) result_i (
    .clk(clk), .rst_n(rst_n), .done(done), .ctl(ctl),
    .prod_hi(prod_hi), .prod_lo(prod_lo), .quot(quot), .rem(rem), .flags(flags),
    .release_ack(release_ack), .rd(rd), .illegal(illegal), .ack(ack)
  );

endmodule

/* tb/mdu_props.sv */
// handshake properties bound into mdu_top
// checked only out of reset except for the reset check itself

module mdu_props #(
  parameter int unsigned XLEN = 32
) (
  input logic            clk,
  input logic            rst_n,
  input logic            req,
  input logic            ack,
  input logic [XLEN-1:0] rd,
  input logic            illegal
);

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> req)
    else $error("ack rose while req was low");

  // held until the requester lets go
  ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && req) |=> ack)
    else $error("ack dropped while req was still high");

  // result must not move under a high ack
  result_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && $past(ack)) |-> ($stable(rd) && $stable(illegal)))
    else $error("rd or illegal changed while ack was high");

  // sync reset clears ack on the next edge
  ack_reset: assert property (@(posedge clk) !rst_n |=> !ack)
    else $error("ack not low after reset");

endmodule

bind mdu_top mdu_props #(.XLEN(XLEN)) props_i (
  .clk(clk), .rst_n(rst_n), .req(req), .ack(ack), .rd(rd), .illegal(illegal)
);

/* tb/mdu_tb.sv */
// testbench for the M extension unit, vectors are for XLEN 32 only
// run from the project root so the vector file path resolves

module mdu_tb;

  import riscv_isa_pkg::*;

  localparam int unsigned XLEN        = 32;
  localparam int unsigned NUM_VEC     = 32;
  localparam int unsigned ACK_TIMEOUT = 4 * XLEN;
  localparam int unsigned REL_TIMEOUT = 16;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            req;
  inst_t           inst;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic            ack;
  logic [XLEN-1:0] rd;
  logic            illegal;

  // five words per vector: inst, rs1, rs2, rd, illegal
  logic [31:0] vec_mem [0:NUM_VEC*5-1];
  logic [15:0] lfsr;

  mdu_top #(.XLEN(XLEN)) dut_i (
    .clk(clk), .rst_n(rst_n), .req(req), .inst(inst), .rs1(rs1), .rs2(rs2),
    .ack(ack), .rd(rd), .illegal(illegal)
  );

  always #5 clk = ~clk;

  ////////////////////////////////
  // helpers
  ////////////////////////////////

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one lfsr step per gap bit
  task automatic draw_gap(output logic [1:0] gap);
    for (int b = 0; b < 2; b++) begin
      gap[b] = lfsr[0];
      lfsr   = lfsr_next(lfsr);
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // polls ack at falling edges, where DUT outputs are settled
  task automatic wait_ack(input logic level, input int unsigned limit,
                          input int unsigned idx);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (ack != level) begin
      if (cycles == limit) begin
        report_failure($sformatf("timeout: ack did not go %s within %0d cycles on vector %0d",
                                 level ? "high" : "low", limit, idx));
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // one full four-phase transfer
  task automatic run_vector(input int unsigned idx);
    logic [31:0] exp_rd;
    logic        exp_illegal;
    exp_rd      = vec_mem[idx*5+3];
    exp_illegal = vec_mem[idx*5+4][0];
    @(posedge clk);
    inst <= inst_t'(vec_mem[idx*5]);
    rs1  <= vec_mem[idx*5+1];
    rs2  <= vec_mem[idx*5+2];
    req  <= 1'b1;
    wait_ack(1'b1, ACK_TIMEOUT, idx);
    assert (rd == exp_rd)
      else report_failure($sformatf("ERR %0t vector %0d: rd %h, expected %h",
                                    $time, idx, rd, exp_rd));
    assert (illegal == exp_illegal)
      else report_failure($sformatf("ERR %0t vector %0d: illegal %b, expected %b",
                                    $time, idx, illegal, exp_illegal));
    // requester side of the return to zero
    @(posedge clk);
    req <= 1'b0;
    wait_ack(1'b0, REL_TIMEOUT, idx);
  endtask

  ////////////////////////////////
  // main sequence
  ////////////////////////////////

  initial begin
    logic [1:0] gap;
    rst_n <= 1'b0;
    req   <= 1'b0;
    inst  <= '0;
    rs1   <= '0;
    rs2   <= '0;
    lfsr  = 16'd87;
    $readmemh("tb/mdu_vectors.hex", vec_mem);
    if (vec_mem[0] == '0) begin
      report_failure("vector file tb/mdu_vectors.hex is missing or empty");
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int unsigned i = 0; i < NUM_VEC; i++) begin
      run_vector(i);
      // random idle gap between transfers
      draw_gap(gap);
      repeat (gap) @(posedge clk);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* verilog.f */
src/riscv_isa_pkg.sv
src/mdu_pkg.sv
src/mdu_decode.sv
src/mdu_execute.sv
src/mdu_result.sv
src/mdu_top.sv
tb/mdu_props.sv
tb/mdu_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mdu_tb
FILELIST  := verilog.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
VECTORS   := tb/mdu_vectors.hex

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	@out=$$(./$(SIM_BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb/mdu_vectors.hex */
// columns: instruction, rs1, rs2, expected rd, expected illegal
// XLEN 32, all fields hex
// MUL
022081B3 00000007 00000006 0000002A 0
022081B3 FFFFFFFD 00000005 FFFFFFF1 0
022081B3 00000000 12345678 00000000 0
022081B3 80000001 80000001 00000001 0
// MULH, MULHSU, MULHU
022091B3 80000000 80000000 40000000 0
022091B3 80000000 FFFFFFFF 00000000 0
022091B3 FFFFFFFF 00000005 FFFFFFFF 0
0220A1B3 FFFFFFFF FFFFFFFF FFFFFFFF 0
0220A1B3 80000000 80000000 C0000000 0
0220A1B3 00000003 FFFFFFFF 00000002 0
0220B1B3 FFFFFFFF FFFFFFFF FFFFFFFE 0
// DIV, REM, DIVU, REMU
0220C1B3 00000014 00000003 00000006 0
0220C1B3 FFFFFFEC 00000003 FFFFFFFA 0
0220C1B3 00000014 FFFFFFFD FFFFFFFA 0
0220E1B3 FFFFFFEC 00000003 FFFFFFFE 0
0220E1B3 00000014 FFFFFFFD 00000002 0
0220D1B3 FFFFFFEC 00000003 5555554E 0
0220F1B3 FFFFFFEC 00000003 00000002 0
0220D1B3 80000000 FFFFFFFF 00000000 0
0220C1B3 7FFFFFFF 00000007 12492492 0
0220F1B3 7FFFFFFF 00000007 00000001 0
// divide by zero and signed overflow
0220C1B3 00001234 00000000 FFFFFFFF 0
0220D1B3 80000000 00000000 FFFFFFFF 0
0220E1B3 FFFFFFEC 00000000 FFFFFFEC 0
0220F1B3 80000000 00000000 80000000 0
0220C1B3 80000000 FFFFFFFF 80000000 0
0220E1B3 80000000 FFFFFFFF 00000000 0
// illegal: ADD, MULW opcode, ADDI, each followed by legal work
002081B3 00000005 00000006 00000000 1
022081B3 00000007 00000006 0000002A 0
022081BB 00000007 00000006 00000000 1
00508193 00000007 00000006 00000000 1
0220C1B3 00000014 00000003 00000006 0
